// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_bridge
BUILD ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f list.f --top-module $(TOP) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model import axi_bridge_pkg::*; (
	input  logic aclk,
	input  logic aresetn,
	input  logic [id_w-1:0] arid,
	input  logic [addr_w-1:0] araddr,
	input  logic [7:0] arlen,
	input  logic arvalid,
	output logic arready,
	output logic [id_w-1:0] rid,
	output logic [data_w-1:0] rdata,
	output logic [1:0] rresp,
	output logic rlast,
	output logic rvalid,
	input  logic rready,
	input  logic [id_w-1:0] awid,
	input  logic [addr_w-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [data_w-1:0] wdata,
	input  logic [data_w/8-1:0] wstrb,
	input  logic wlast,
	input  logic wvalid,
	output logic wready,
	output logic [id_w-1:0] bid,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready
);
	logic [data_w-1:0] mem [0:1023];
	logic [31:0] lfsr = 32'h86be;
	logic [addr_w-1:0] aw_q [$]; // accepted AW, oldest first
	logic [id_w-1:0] awid_q [$];
	logic [data_w-1:0] wd_q [$];
	logic [data_w/8-1:0] ws_q [$];
	logic wl_q [$];
	int bursts_done = 0;

	// taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic int stall_cycles();
		int n;
		n = lfsr_bit();
		n = n * 2 + lfsr_bit();
		return n;
	endfunction

	task automatic stall();
		int n;
		n = stall_cycles();
		repeat (n) begin
			@(posedge aclk);
			#1;
		end
	endtask

	initial begin
		for (int i = 0; i < 1024; i++)
			mem[i] = i * 32'h01010101 + 32'd1;
	end

	initial begin : read_side
		logic [9:0] idx;
		logic [7:0] len;
		logic [id_w-1:0] id;
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		rid = '0;
		rresp = 2'b00;
		forever begin
			@(posedge aclk);
			#1;
			if (aresetn && arvalid) begin
				stall();
				idx = araddr[11:2];
				len = arlen;
				id = arid;
				arready = 1'b1;
				@(posedge aclk);
				#1 arready = 1'b0;
				for (int i = 0; i <= len; i++) begin
					stall();
					rvalid = 1'b1;
					rid = id;
					rdata = mem[idx];
					rlast = i == len;
					do @(posedge aclk); while (!rready);
					#1 rvalid = 1'b0;
					rlast = 1'b0;
					idx++; // incrementing burst
				end
			end
		end
	end

	initial begin : aw_side
		logic [addr_w-1:0] a;
		logic [id_w-1:0] id;
		awready = 1'b0;
		forever begin
			@(posedge aclk);
			#1;
			if (aresetn && awvalid) begin
				stall();
				a = awaddr;
				id = awid;
				awready = 1'b1;
				@(posedge aclk);
				#1 awready = 1'b0;
				aw_q.push_back(a);
				awid_q.push_back(id);
			end
		end
	end

	initial begin : w_side
		logic [data_w-1:0] d;
		logic [data_w/8-1:0] s;
		logic l;
		wready = 1'b0;
		forever begin
			@(posedge aclk);
			#1;
			if (aresetn && wvalid) begin
				stall();
				d = wdata;
				s = wstrb;
				l = wlast;
				wready = 1'b1;
				@(posedge aclk);
				#1 wready = 1'b0;
				wd_q.push_back(d);
				ws_q.push_back(s);
				wl_q.push_back(l);
				if (l)
					bursts_done++;
			end
		end
	end

	initial begin : b_side
		logic [9:0] idx;
		logic [id_w-1:0] id;
		logic [data_w-1:0] d;
		logic [data_w/8-1:0] s;
		logic l;
		bvalid = 1'b0;
		bid = '0;
		bresp = 2'b00;
		forever begin
			@(posedge aclk);
			#1;
			if (aw_q.size() > 0 && bursts_done > 0) begin
				idx = aw_q.pop_front() >> 2;
				id = awid_q.pop_front();
				do begin
					d = wd_q.pop_front();
					s = ws_q.pop_front();
					l = wl_q.pop_front();
					for (int b = 0; b < 4; b++)
						if (s[b]) mem[idx][8*b +: 8] = d[8*b +: 8];
					idx++;
				end while (!l);
				bursts_done--;
				stall();
				bvalid = 1'b1;
				bid = id;
				do @(posedge aclk); while (!bready);
				#1 bvalid = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/bridge_chk.sv
`timescale 1ns/1ps
`default_nettype none

module bridge_chk (
	input logic aclk,
	input logic aresetn,
	input logic a_valid,
	input logic a_ready,
	input logic [46:0] a_payload,
	input logic w_valid,
	input logic w_ready,
	input logic w_last,
	input logic b_valid,
	input logic b_ready
);
	logic [7:0] a_len;
	logic [7:0] w_cnt; // W beats accepted in this burst
	logic a_seen; // address accepted since the last B
	logic w_seen; // last W beat accepted since the last B

	assign a_len = a_payload[10:3]; // len sits just above the size field

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			w_cnt <= 8'd0;
			a_seen <= 1'b0;
			w_seen <= 1'b0;
		end else begin
			if (w_valid && w_ready)
				w_cnt <= w_last ? 8'd0 : w_cnt + 8'd1;
			if (b_valid && b_ready) begin
				a_seen <= 1'b0;
				w_seen <= 1'b0;
			end else begin
				if (a_valid && a_ready)
					a_seen <= 1'b1;
				if (w_valid && w_ready && w_last)
					w_seen <= 1'b1;
			end
		end
	end

	// address channel holds until ready
	a_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		a_valid && !a_ready |=> a_valid && $stable(a_payload))
		else $error("address valid or payload changed before ready");

	w_last_valid: assert property (@(posedge aclk) disable iff (!aresetn)
		w_valid || w_last |-> w_valid && (w_last == (w_cnt == a_len)))
		else $error("wlast without wvalid or not on beat awlen");

	b_after_aw_w: assert property (@(posedge aclk) disable iff (!aresetn)
		b_ready |-> a_seen && w_seen && !a_valid && !w_valid)
		else $error("bready before AW and the last W were accepted");

endmodule

bind axi_read_engine bridge_chk u_chk_rd (
	.aclk(aclk), .aresetn(aresetn), .a_valid(arvalid), .a_ready(arready),
	.a_payload({arid, araddr, arlen, arsize}),
	.w_valid(1'b0), .w_ready(1'b0), .w_last(1'b0), .b_valid(1'b0), .b_ready(1'b0)
);

bind axi_write_engine bridge_chk u_chk_wr (
	.aclk(aclk), .aresetn(aresetn), .a_valid(awvalid), .a_ready(awready),
	.a_payload({awid, awaddr, awlen, awsize}),
	.w_valid(wvalid), .w_ready(wready), .w_last(wlast), .b_valid(bvalid), .b_ready(bready)
);

`default_nettype wire

// File: bench/tb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bridge import axi_bridge_pkg::*; ();
	localparam int limit = 300; // cycles per wait

	logic aclk, aresetn;
	logic [id_w-1:0] arid, rid, awid, wid, bid;
	logic [addr_w-1:0] araddr, awaddr;
	logic [7:0] arlen, awlen;
	logic [2:0] arsize, arprot, awsize, awprot;
	logic [1:0] arburst, arlock, awburst, awlock, rresp, bresp;
	logic [3:0] arcache, awcache;
	logic arvalid, arready, rvalid, rready, rlast;
	logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
	logic [data_w-1:0] rdata, wdata;
	logic [data_w/8-1:0] wstrb;
	logic icache_rd_req, icache_rd_rdy, icache_ret_valid, icache_ret_last;
	logic [addr_w-1:0] icache_rd_addr, dcache_rd_addr, dcache_wr_addr, data_sram_addr;
	logic [data_w-1:0] icache_ret_data, dcache_ret_data, data_sram_rdata, data_sram_wdata;
	logic dcache_rd_req, dcache_wr_req, dcache_rd_rdy, dcache_ret_valid;
	logic dcache_ret_last, dcache_wr_rdy;
	logic [2:0] dcache_rd_type, dcache_wr_type;
	logic [data_w/8-1:0] dcache_wr_wstrb, data_sram_wstrb;
	logic [line_w-1:0] dcache_wr_data;
	logic data_sram_req, data_sram_wr, data_sram_addr_ok, data_sram_data_ok;
	logic [1:0] data_sram_size;

	logic [data_w-1:0] shadow [0:1023]; // expected memory contents
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle = 0;
	event timeout_ev;

	bridge_sram_axi i_dut (.*);
	axi_mem_model u_mem (.*);

	initial begin
		aclk = 1'b0;
		forever #50 aclk = ~aclk;
	end

	always @(posedge aclk) cycle <= cycle + 1;

	// ends the run when any wait gives up
	initial begin
		@(timeout_ev);
		$display("SOME TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] d,
		input logic [3:0] s);
		logic [31:0] r;
		r = old;
		for (int b = 0; b < 4; b++)
			if (s[b]) r[8*b +: 8] = d[8*b +: 8];
		return r;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error %s: got %h, expected %h", what, got, exp);
			errors++;
		end
	endtask

	task automatic timed_out(input string what);
		$display("timeout while waiting for %s", what);
		-> timeout_ev;
		forever @(posedge aclk); // the watchdog ends the run
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors > err_before) begin
			tests_failed++;
			$display("%s: failed", name);
		end else begin
			$display("%s: passed", name);
		end
	endtask

	// fixed AXI fields at each handshake
	always @(posedge aclk) begin
		if (aresetn && arvalid && arready) begin
			check_value("arburst", arburst, burst_incr);
			check_value("arsize", arsize, size_word);
			check_value("arlock", arlock, 2'b00);
			check_value("arcache", arcache, 4'b0000);
			check_value("arprot", arprot, 3'b000);
		end
		if (aresetn && awvalid && awready) begin
			check_value("awid", awid, id_data);
			check_value("awburst", awburst, burst_incr);
			check_value("awsize", awsize, size_word);
			check_value("awlock", awlock, 2'b00);
			check_value("awcache", awcache, 4'b0000);
			check_value("awprot", awprot, 3'b000);
		end
		if (aresetn && wvalid && wready)
			check_value("wid", wid, id_data);
	end

	// src 0 icache, 1 dcache, 2 data sram; returns at edge plus 1 ns
	task automatic read_req(input int src, input logic [31:0] addr, input logic [2:0] typ);
		int t;
		logic hit;
		t = 0;
		hit = 1'b0;
		case (src)
			0: begin
				icache_rd_req = 1'b1;
				icache_rd_addr = addr;
			end
			1: begin
				dcache_rd_req = 1'b1;
				dcache_rd_addr = addr;
				dcache_rd_type = typ;
			end
			default: begin
				data_sram_req = 1'b1;
				data_sram_wr = 1'b0;
				data_sram_addr = addr;
			end
		endcase
		while (!hit) begin
			@(posedge aclk);
			hit = (src == 0) ? icache_rd_rdy : (src == 1) ? dcache_rd_rdy : data_sram_addr_ok;
			t++;
			if (!hit && t > limit) timed_out("read address accept");
		end
		#1;
		case (src)
			0: icache_rd_req = 1'b0;
			1: dcache_rd_req = 1'b0;
			default: data_sram_req = 1'b0;
		endcase
	endtask

	task automatic read_data(input int src, output int n, output logic [31:0] w [0:3]);
		int t;
		logic v;
		logic l;
		t = 0;
		n = 0;
		l = 1'b0;
		while (!l) begin
			@(posedge aclk);
			v = (src == 0) ? icache_ret_valid : (src == 1) ? dcache_ret_valid : data_sram_data_ok;
			l = (src == 0) ? icache_ret_last : (src == 1) ? dcache_ret_last : data_sram_data_ok;
			if (v && n < 4)
				w[n] = (src == 0) ? icache_ret_data :
					(src == 1) ? dcache_ret_data : data_sram_rdata;
			if (v) n++;
			t++;
			if (!l && t > limit) timed_out("read data");
		end
		#1;
	endtask

	// AR fields of the read just accepted, still held by decode
	task automatic check_ar(input string name, input int src, input int beats);
		check_value({name, " arlen"}, arlen, beats - 1);
		check_value({name, " arid bit 0"}, arid[0], src != 0);
	endtask

	task automatic check_return(input string name, input int src, input logic [31:0] addr,
		input int beats);
		int n;
		logic [31:0] w [0:3];
		read_data(src, n, w);
		check_value({name, " beat count"}, n, beats);
		for (int i = 0; i < beats && i < n; i++)
			check_value({name, " ret_data"}, w[i], shadow[(addr >> 2) + i]);
	endtask

	task automatic check_read(input string name, input int src, input logic [31:0] addr,
		input logic [2:0] typ, input int beats);
		read_req(src, addr, typ);
		check_ar(name, src, beats);
		check_return(name, src, addr, beats);
	endtask

	task automatic icache_fill_test();
		int e;
		e = errors;
		check_read("icache_ret", 0, 32'h100, type_line, 4);
		finish_test("icache fill", e);
	endtask

	task automatic dcache_read_test();
		int e;
		e = errors;
		check_read("dcache_single", 1, 32'h204, 3'b010, 1);
		check_read("dcache_line", 1, 32'h300, type_line, 4);
		finish_test("dcache reads", e);
	endtask

	task automatic sram_write_read_test();
		int e;
		int t;
		e = errors;
		t = 0;
		data_sram_req = 1'b1;
		data_sram_wr = 1'b1;
		data_sram_addr = 32'h408;
		data_sram_wdata = 32'haabbccdd;
		data_sram_wstrb = 4'b0110;
		do begin
			@(posedge aclk);
			t++;
			if (!data_sram_addr_ok && t > limit) timed_out("data sram write addr_ok");
		end while (!data_sram_addr_ok);
		#1 data_sram_req = 1'b0;
		shadow[32'h408 >> 2] = merge(shadow[32'h408 >> 2], 32'haabbccdd, 4'b0110);
		t = 0;
		do begin
			@(posedge aclk);
			t++;
			if (!data_sram_data_ok && t > limit) timed_out("data sram write data_ok");
		end while (!data_sram_data_ok);
		#1;
		check_read("data_sram_rdata", 2, 32'h408, 3'b010, 1);
		finish_test("data sram partial write", e);
	endtask

	task automatic line_write_hazard_test();
		int e;
		int t;
		logic [127:0] line;
		e = errors;
		t = 0;
		line = 128'h44443333_22221111_cafe0002_beef0001;
		dcache_wr_req = 1'b1;
		dcache_wr_type = type_line;
		dcache_wr_addr = 32'h500;
		dcache_wr_wstrb = 4'hf;
		dcache_wr_data = line;
		do begin
			@(posedge aclk);
			t++;
			if (!dcache_wr_rdy && t > limit) timed_out("dcache write accept");
		end while (!dcache_wr_rdy);
		#1 dcache_wr_req = 1'b0;
		for (int i = 0; i < 4; i++)
			shadow[(32'h500 >> 2) + i] = line[32*i +: 32];
		// fill goes out while the write is still open
		check_read("icache_after_write", 0, 32'h500, type_line, 4);
		finish_test("line write then fill", e);
	endtask

	task automatic same_cycle_test();
		int e;
		int t_sram;
		int t_ic;
		e = errors;
		fork
			begin
				read_req(2, 32'h704, 3'b010);
				t_sram = cycle;
				check_ar("sram_first", 2, 1);
				check_return("sram_first", 2, 32'h704, 1);
			end
			begin
				read_req(0, 32'h600, type_line);
				t_ic = cycle;
				check_ar("icache_second", 0, 4);
				check_return("icache_second", 0, 32'h600, 4);
			end
		join
		if (t_sram >= t_ic) begin
			$display("data sram addr_ok did not come before icache_rd_rdy");
			errors++;
		end
		finish_test("sram over icache order", e);
	endtask

	initial begin
		aresetn = 1'b0;
		icache_rd_req = 1'b0;
		icache_rd_addr = '0;
		dcache_rd_req = 1'b0;
		dcache_rd_type = 3'b000;
		dcache_rd_addr = '0;
		dcache_wr_req = 1'b0;
		dcache_wr_type = 3'b000;
		dcache_wr_addr = '0;
		dcache_wr_wstrb = '0;
		dcache_wr_data = '0;
		data_sram_req = 1'b0;
		data_sram_wr = 1'b0;
		data_sram_size = 2'd2;
		data_sram_addr = '0;
		data_sram_wdata = '0;
		data_sram_wstrb = '0;
		for (int i = 0; i < 1024; i++)
			shadow[i] = i * 32'h01010101 + 32'd1;
		repeat (8) @(posedge aclk);
		#1 aresetn = 1'b1;
		icache_fill_test();
		dcache_read_test();
		sram_write_read_test();
		line_write_hazard_test();
		same_cycle_test();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/axi_bridge_pkg.sv
`default_nettype none

package axi_bridge_pkg;

	// bus widths
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int line_w = 128;
	localparam int id_w = 4;

	// bit 0 of the id splits instruction from data
	localparam logic [id_w-1:0] id_inst = 4'd0;
	localparam logic [id_w-1:0] id_data = 4'd1;
	localparam logic [id_w-1:0] id_sram = 4'd3; // data id, source bit 1 set for data sram

	// request type from the caches
	localparam logic [2:0] type_line = 3'b100;

	// axi field codes
	localparam logic [7:0] line_len = 8'd3; // four beats
	localparam logic [1:0] burst_incr = 2'b01;
	localparam logic [2:0] size_word = 3'b010;

endpackage

`default_nettype wire

// File: hdl/axi_read_engine.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_engine import axi_bridge_pkg::*; (
	input  logic aclk,
	input  logic aresetn,
	input  logic rd_start,
	input  logic [id_w-1:0] ar_id,
	input  logic [addr_w-1:0] ar_addr,
	input  logic [7:0] ar_len,
	input  logic [2:0] ar_size,
	output logic [id_w-1:0] arid,
	output logic [addr_w-1:0] araddr,
	output logic [7:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic [1:0] arlock,
	output logic [3:0] arcache,
	output logic [2:0] arprot,
	output logic arvalid,
	input  logic arready,
	input  logic [id_w-1:0] rid,
	input  logic [data_w-1:0] rdata,
	input  logic [1:0] rresp,
	input  logic rlast,
	input  logic rvalid,
	output logic rready,
	output logic ar_idle,
	output logic r_beat,
	output logic r_last,
	output logic [id_w-1:0] r_id_q,
	output logic [data_w-1:0] r_data_q
);
	typedef enum logic [1:0] {ar_s_idle = 2'b01, ar_s_req = 2'b10} ar_state_t;
	typedef enum logic [1:0] {r_s_idle = 2'b01, r_s_recv = 2'b10} r_state_t;

	ar_state_t ar_state;
	ar_state_t ar_next;
	r_state_t r_state;
	r_state_t r_next;
	logic [1:0] outstanding; // AR accepted, last R not yet seen
	logic ar_hs;
	logic r_hs;
	logic r_done;

	// fields are held stable by decode while AR is busy
	assign arid = ar_id;
	assign araddr = ar_addr;
	assign arlen = ar_len;
	assign arsize = ar_size;
	assign arburst = burst_incr;
	assign arlock = 2'b00;
	assign arcache = 4'b0000;
	assign arprot = 3'b000;

	assign arvalid = ar_state == ar_s_req;
	assign rready = r_state == r_s_recv;
	assign ar_hs = arvalid & arready;
	assign r_hs = rvalid & rready;
	assign r_done = r_hs & rlast;
	assign ar_idle = (ar_state == ar_s_idle) & (outstanding == 2'd0); // one read at a time

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			ar_state <= ar_s_idle;
			r_state <= r_s_idle;
		end else begin
			ar_state <= ar_next;
			r_state <= r_next;
		end
	end

	always_comb begin
		ar_next = ar_state;
		case (ar_state)
			ar_s_idle: if (rd_start && ar_idle) ar_next = ar_s_req;
			ar_s_req:  if (arready) ar_next = ar_s_idle;
			default:   ar_next = ar_s_idle;
		endcase
	end

	always_comb begin
		r_next = r_state;
		case (r_state)
			r_s_idle: if (ar_hs || outstanding != 2'd0) r_next = r_s_recv;
			r_s_recv: if (r_done && !ar_hs && outstanding == 2'd1) r_next = r_s_idle;
			default:  r_next = r_s_idle;
		endcase
	end

	// a new AR and the last R of the previous burst cancel out
	always_ff @(posedge aclk) begin
		if (!aresetn)
			outstanding <= 2'd0;
		else if (ar_hs && !r_done)
			outstanding <= outstanding + 2'd1;
		else if (r_done && !ar_hs)
			outstanding <= outstanding - 2'd1;
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			r_beat <= 1'b0;
			r_last <= 1'b0;
		end else begin
			r_beat <= r_hs;
			r_last <= r_done;
		end
	end

	always_ff @(posedge aclk) begin
		if (r_hs) begin
			r_id_q <= rid;
			r_data_q <= rdata;
		end
	end

endmodule

`default_nettype wire

// File: hdl/axi_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_engine import axi_bridge_pkg::*; (
	input  logic aclk,
	input  logic aresetn,
	input  logic wr_start,
	input  logic [addr_w-1:0] aw_addr,
	input  logic [7:0] aw_len,
	input  logic [2:0] aw_size,
	input  logic [data_w/8-1:0] w_strb,
	input  logic [line_w-1:0] wr_line,
	input  logic wr_single,
	output logic [id_w-1:0] awid,
	output logic [addr_w-1:0] awaddr,
	output logic [7:0] awlen,
	output logic [2:0] awsize,
	output logic [1:0] awburst,
	output logic [1:0] awlock,
	output logic [3:0] awcache,
	output logic [2:0] awprot,
	output logic awvalid,
	output logic [id_w-1:0] wid,
	output logic [data_w-1:0] wdata,
	output logic [data_w/8-1:0] wstrb,
	output logic wlast,
	output logic wvalid,
	input  logic awready,
	input  logic wready,
	input  logic [id_w-1:0] bid,
	input  logic [1:0] bresp,
	input  logic bvalid,
	output logic bready,
	output logic w_idle,
	output logic w_pending,
	output logic b_done
);
	typedef enum logic [4:0] {
		w_s_idle    = 5'b00001,
		w_s_start   = 5'b00010, // AW and W both open
		w_s_aw_done = 5'b00100,
		w_s_w_done  = 5'b01000,
		w_s_b       = 5'b10000
	} w_state_t;

	w_state_t w_state;
	w_state_t w_next;
	logic [1:0] beat_cnt;
	logic [line_w-1:0] line_sr; // beats still to send
	logic aw_hs;
	logic w_hs;
	logic w_end;

	assign awid = id_data;
	assign awaddr = aw_addr;
	assign awlen = aw_len;
	assign awsize = aw_size;
	assign awburst = burst_incr;
	assign awlock = 2'b00;
	assign awcache = 4'b0000;
	assign awprot = 3'b000;
	assign wid = id_data;
	assign wstrb = w_strb;

	// first beat straight from the captured line
	assign wdata = (beat_cnt == 2'd0) ? wr_line[data_w-1:0] : line_sr[data_w-1:0];
	assign wlast = wvalid & ({6'b0, beat_cnt} == aw_len);

	assign awvalid = (w_state == w_s_start) | (w_state == w_s_w_done);
	assign wvalid = (w_state == w_s_start) | (w_state == w_s_aw_done);
	assign bready = w_state == w_s_b;
	assign aw_hs = awvalid & awready;
	assign w_hs = wvalid & wready;
	assign w_end = w_hs & wlast;
	assign b_done = bvalid & bready & (bid == awid);

	assign w_idle = w_state == w_s_idle;
	assign w_pending = wr_start | (~w_idle & ~b_done);

	always_ff @(posedge aclk) begin
		if (!aresetn)
			w_state <= w_s_idle;
		else
			w_state <= w_next;
	end

	always_comb begin
		w_next = w_state;
		case (w_state)
			w_s_idle: if (wr_start) w_next = w_s_start;
			w_s_start: begin
				if (aw_hs && w_end)
					w_next = w_s_b;
				else if (aw_hs)
					w_next = w_s_aw_done;
				else if (w_end)
					w_next = w_s_w_done;
			end
			w_s_aw_done: if (w_end) w_next = w_s_b;
			w_s_w_done:  if (aw_hs) w_next = w_s_b;
			w_s_b:       if (b_done) w_next = w_s_idle;
			default:     w_next = w_s_idle;
		endcase
	end

	always_ff @(posedge aclk) begin
		if (!aresetn)
			beat_cnt <= 2'd0;
		else if (w_end)
			beat_cnt <= 2'd0;
		else if (w_hs)
			beat_cnt <= beat_cnt + 2'd1;
	end

	// single word never needs the shift
	always_ff @(posedge aclk) begin
		if (w_hs && !wr_single)
			line_sr <= (beat_cnt == 2'd0) ? wr_line >> data_w : line_sr >> data_w;
	end

endmodule

`default_nettype wire

// File: hdl/bridge_sram_axi.sv
`timescale 1ns/1ps
`default_nettype none

module bridge_sram_axi import axi_bridge_pkg::*; (
	input  logic aclk,
	input  logic aresetn,
	// AR and R
	output logic [id_w-1:0] arid,
	output logic [addr_w-1:0] araddr,
	output logic [7:0] arlen,
	output logic [2:0] arsize, arprot,
	output logic [1:0] arburst, arlock,
	output logic [3:0] arcache,
	output logic arvalid, rready,
	input  logic arready, rlast, rvalid,
	input  logic [id_w-1:0] rid,
	input  logic [data_w-1:0] rdata,
	input  logic [1:0] rresp,
	// AW, W and B
	output logic [id_w-1:0] awid, wid,
	output logic [addr_w-1:0] awaddr,
	output logic [7:0] awlen,
	output logic [2:0] awsize, awprot,
	output logic [1:0] awburst, awlock,
	output logic [3:0] awcache,
	output logic awvalid, wlast, wvalid, bready,
	output logic [data_w-1:0] wdata,
	output logic [data_w/8-1:0] wstrb,
	input  logic awready, wready, bvalid,
	input  logic [id_w-1:0] bid,
	input  logic [1:0] bresp,
	// icache read
	input  logic icache_rd_req,
	input  logic [addr_w-1:0] icache_rd_addr,
	output logic icache_rd_rdy, icache_ret_valid, icache_ret_last,
	output logic [data_w-1:0] icache_ret_data,
	// dcache read and write
	input  logic dcache_rd_req, dcache_wr_req,
	input  logic [2:0] dcache_rd_type, dcache_wr_type,
	input  logic [addr_w-1:0] dcache_rd_addr, dcache_wr_addr,
	input  logic [data_w/8-1:0] dcache_wr_wstrb,
	input  logic [line_w-1:0] dcache_wr_data,
	output logic dcache_rd_rdy, dcache_ret_valid, dcache_ret_last, dcache_wr_rdy,
	output logic [data_w-1:0] dcache_ret_data,
	// uncached data sram
	input  logic data_sram_req, data_sram_wr,
	input  logic [1:0] data_sram_size,
	input  logic [addr_w-1:0] data_sram_addr,
	input  logic [data_w-1:0] data_sram_wdata,
	input  logic [data_w/8-1:0] data_sram_wstrb,
	output logic data_sram_addr_ok, data_sram_data_ok,
	output logic [data_w-1:0] data_sram_rdata
);
	logic rd_start, ar_idle, r_beat, r_last;
	logic [id_w-1:0] ar_id, r_id_q;
	logic [addr_w-1:0] ar_addr, aw_addr;
	logic [7:0] ar_len, aw_len;
	logic [2:0] ar_size, aw_size;
	logic [data_w-1:0] r_data_q;
	logic wr_start, wr_single, w_idle, w_pending, b_done, aw_from_sram;
	logic [data_w/8-1:0] w_strb;
	logic [line_w-1:0] wr_line;

	assign dcache_wr_rdy = w_idle;

	req_decode u_decode (.*);
	axi_read_engine u_rd (.*);
	axi_write_engine u_wr (.*);
	resp_route u_route (.*);

endmodule

`default_nettype wire

// File: hdl/req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module req_decode import axi_bridge_pkg::*; (
	input  logic aclk,
	input  logic aresetn,
	input  logic icache_rd_req,
	input  logic [addr_w-1:0] icache_rd_addr,
	input  logic dcache_rd_req,
	input  logic [2:0] dcache_rd_type,
	input  logic [addr_w-1:0] dcache_rd_addr,
	input  logic dcache_wr_req,
	input  logic [2:0] dcache_wr_type,
	input  logic [addr_w-1:0] dcache_wr_addr,
	input  logic [data_w/8-1:0] dcache_wr_wstrb,
	input  logic [line_w-1:0] dcache_wr_data,
	input  logic data_sram_req,
	input  logic data_sram_wr,
	input  logic [1:0] data_sram_size,
	input  logic [addr_w-1:0] data_sram_addr,
	input  logic [data_w-1:0] data_sram_wdata,
	input  logic [data_w/8-1:0] data_sram_wstrb,
	input  logic ar_idle,
	input  logic w_idle,
	input  logic w_pending,
	output logic rd_start,
	output logic [id_w-1:0] ar_id,
	output logic [addr_w-1:0] ar_addr,
	output logic [7:0] ar_len,
	output logic [2:0] ar_size,
	output logic wr_start,
	output logic [addr_w-1:0] aw_addr,
	output logic [7:0] aw_len,
	output logic [2:0] aw_size,
	output logic [data_w/8-1:0] w_strb,
	output logic [line_w-1:0] wr_line,
	output logic wr_single,
	output logic aw_from_sram
);
	logic sram_rd;
	logic sram_wr;
	logic dc_line_wr;
	logic hazard;
	logic [addr_w-1:0] rd_cand;
	logic [addr_w-1:0] wr_cand;
	logic [addr_w-1:0] wr_cmp;

	assign sram_rd = data_sram_req & ~data_sram_wr;
	assign sram_wr = data_sram_req & data_sram_wr;
	assign dc_line_wr = dcache_wr_type == type_line;

	// data sram first, then dcache, then icache
	assign rd_cand = sram_rd ? data_sram_addr : dcache_rd_req ? dcache_rd_addr : icache_rd_addr;
	assign wr_cand = dcache_wr_req ? dcache_wr_addr : data_sram_addr; // dcache has no retry

	// aw_addr is only valid once the write is captured
	assign wr_cmp = w_idle ? wr_cand : aw_addr;
	// compared per line, so a word write also holds a line fill over it
	assign hazard = w_pending & (rd_cand[addr_w-1:4] == wr_cmp[addr_w-1:4]);

	assign rd_start = ar_idle & (sram_rd | dcache_rd_req | icache_rd_req) & ~hazard;
	assign wr_start = w_idle & (dcache_wr_req | sram_wr);

	always_ff @(posedge aclk) begin
		if (rd_start) begin
			ar_addr <= rd_cand;
			if (sram_rd) begin
				ar_id <= id_sram;
				ar_len <= 8'd0;
				ar_size <= {1'b0, data_sram_size};
			end else if (dcache_rd_req) begin
				ar_id <= id_data;
				ar_len <= (dcache_rd_type == type_line) ? line_len : 8'd0;
				ar_size <= size_word;
			end else begin
				ar_id <= id_inst;
				ar_len <= line_len; // icache always fills a line
				ar_size <= size_word;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (wr_start) begin
			aw_addr <= wr_cand;
			if (dcache_wr_req) begin
				aw_len <= dc_line_wr ? line_len : 8'd0;
				aw_size <= size_word;
				w_strb <= dc_line_wr ? 4'hf : dcache_wr_wstrb;
				wr_line <= dc_line_wr ? dcache_wr_data :
					{{(line_w-data_w){1'b0}}, dcache_wr_data[data_w-1:0]};
				wr_single <= ~dc_line_wr;
			end else begin
				aw_len <= 8'd0;
				aw_size <= {1'b0, data_sram_size};
				w_strb <= data_sram_wstrb;
				wr_line <= {{(line_w-data_w){1'b0}}, data_sram_wdata}; // word in low lane
				wr_single <= 1'b1;
			end
		end
	end

	// held until the engine is idle again, so it covers the B response
	always_ff @(posedge aclk) begin
		if (!aresetn)
			aw_from_sram <= 1'b0;
		else if (wr_start)
			aw_from_sram <= ~dcache_wr_req;
	end

endmodule

`default_nettype wire

// File: hdl/resp_route.sv
`timescale 1ns/1ps
`default_nettype none

module resp_route import axi_bridge_pkg::*; (
	input  logic [id_w-1:0] ar_id,
	input  logic arvalid,
	input  logic arready,
	input  logic awvalid,
	input  logic awready,
	input  logic r_beat,
	input  logic r_last,
	input  logic [id_w-1:0] r_id_q,
	input  logic [data_w-1:0] r_data_q,
	input  logic b_done,
	input  logic aw_from_sram,
	output logic icache_rd_rdy,
	output logic icache_ret_valid,
	output logic icache_ret_last,
	output logic [data_w-1:0] icache_ret_data,
	output logic dcache_rd_rdy,
	output logic dcache_ret_valid,
	output logic dcache_ret_last,
	output logic [data_w-1:0] dcache_ret_data,
	output logic data_sram_addr_ok,
	output logic data_sram_data_ok,
	output logic [data_w-1:0] data_sram_rdata
);
	logic ar_hs;
	logic rd_inst; // AR side source
	logic rd_sram;
	logic ret_inst; // R side source, from the echoed id
	logic ret_sram;

	assign ar_hs = arvalid & arready;
	assign rd_inst = ~ar_id[0];
	assign rd_sram = ar_id == id_sram;
	assign ret_inst = ~r_id_q[0];
	assign ret_sram = r_id_q == id_sram;

	assign icache_rd_rdy = ar_hs & rd_inst;
	assign dcache_rd_rdy = ar_hs & ~rd_inst & ~rd_sram;
	assign data_sram_addr_ok = (ar_hs & rd_sram) | (awvalid & awready & aw_from_sram);

	assign icache_ret_valid = r_beat & ret_inst;
	assign icache_ret_last = r_last & ret_inst;
	assign dcache_ret_valid = r_beat & ~ret_inst & ~ret_sram;
	assign dcache_ret_last = r_last & ~ret_inst & ~ret_sram;
	assign data_sram_data_ok = (r_last & ret_sram) | (b_done & aw_from_sram);

	// one read buffer shared by all three
	assign icache_ret_data = r_data_q;
	assign dcache_ret_data = r_data_q;
	assign data_sram_rdata = r_data_q;

endmodule

`default_nettype wire

// File: list.f
hdl/axi_bridge_pkg.sv
hdl/req_decode.sv
hdl/axi_read_engine.sv
hdl/axi_write_engine.sv
hdl/resp_route.sv
hdl/bridge_sram_axi.sv
bench/axi_mem_model.sv
bench/bridge_chk.sv
bench/tb_bridge.sv
